// ==== source/frontEnd_cfg.svh ====
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// Lanes delivered by fetch in one bundle.
`define FETCH_WIDTH 4

// Instructions that leave the queue together as one dispatch group.
`define DISPATCH_WIDTH 2

// Queue entries. Must stay a power of two so the pointers wrap for free.
`define IQ_DEPTH 16
`define IQ_DEPTH_LOG 4  // Pointer width, log2 of IQ_DEPTH.

// Width of a raw instruction word. The decoded immediate and the pc share it.
`define INST_WIDTH 16

`endif

// ==== source/instFormatPkg.sv ====
`include "frontEnd_cfg.svh"

// Describes a single instruction, both as fetched and as decoded.
package instFormatPkg;

  // Raw opcodes 0 to 7 map one to one. Everything with the top bit set is illegal.
  typedef enum logic [3:0] {
    opAdd     = 4'h0,
    opSub     = 4'h1,
    opAnd     = 4'h2,
    opOr      = 4'h3,
    opLoad    = 4'h4,
    opStore   = 4'h5,
    opBranch  = 4'h6,
    opJump    = 4'h7,
    opIllegal = 4'hF
  } opcodeT;

  // Coarse class used by later stages to steer the instruction.
  typedef enum logic [1:0] {
    classAlu  = 2'd0,
    classMem  = 2'd1,
    classCtrl = 2'd2,
    classBad  = 2'd3
  } instClassT;

  // The raw 16-bit encoding, opcode in the top nibble.
  typedef struct packed {
    logic [3:0] opcode;  // Bits 15 to 12.
    logic [3:0] rd;      // Bits 11 to 8.
    logic [3:0] rs;      // Bits 7 to 4.
    logic [3:0] imm4;    // Bits 3 to 0, signed.
  } rawInstT;

  // One decoded instruction as it sits in the queue.
  typedef struct packed {
    opcodeT                  opcode;
    instClassT               instClass;
    logic                    isBranch;  // Set for opBranch and opJump only.
    logic [3:0]              rd;
    logic [3:0]              rs;
    logic [`INST_WIDTH-1:0]  imm;       // Sign-extended imm4.
    logic [`INST_WIDTH-1:0]  pc;
  } decodedInstT;

endpackage

// ==== source/bundlePkg.sv ====
`include "frontEnd_cfg.svh"

// Describes what travels between the stages of the front end.
package bundlePkg;

  // A fetch bundle. Lane k sits at basePc plus k.
  typedef struct packed {
    logic [`FETCH_WIDTH-1:0]                      laneValid;
    logic [`INST_WIDTH-1:0]                       basePc;
    instFormatPkg::rawInstT [`FETCH_WIDTH-1:0]    lane;
  } fetchBundleT;

  // Decoder output. The lanes keep their fetch positions, so holes are allowed.
  typedef struct packed {
    logic [`FETCH_WIDTH-1:0]                      laneValid;
    instFormatPkg::decodedInstT [`FETCH_WIDTH-1:0] lane;
  } decodedBundleT;

  // A dispatch group, always full.
  // Slot 0 holds the oldest instruction.
  typedef struct packed {
    instFormatPkg::decodedInstT [`DISPATCH_WIDTH-1:0] slot;
  } dispatchBundleT;

endpackage

// ==== source/instDecoder.sv ====
`include "frontEnd_cfg.svh"

// Decode stage for a full fetch bundle.
// All lanes are decoded in parallel and the result is registered, so a bundle
// accepted on one edge reaches the queue on the next.
module instDecoder (
  input  logic                      clk,
  input  logic                      rstN_i,
  input  logic                      flush_i,
  input  logic                      fetchValid_i,
  input  bundlePkg::fetchBundleT    fetchBundle_i,
  input  logic                      stallFetch_i,    // From the queue.
  output logic                      decodedValid_o,
  output bundlePkg::decodedBundleT  decodedBundle_o
);

  logic                     accept;       // A bundle is taken on this edge.
  bundlePkg::decodedBundleT decodedNext;  // Combinational decode of the input bundle.

  // Turns one raw lane into its decoded form.
  function automatic instFormatPkg::decodedInstT decodeLane(
    input instFormatPkg::rawInstT raw,
    input logic [`INST_WIDTH-1:0] lanePc
  );
    instFormatPkg::decodedInstT dec;
    // The top opcode bit marks the illegal half of the encoding space.
    dec.opcode = raw.opcode[3] ? instFormatPkg::opIllegal
                               : instFormatPkg::opcodeT'(raw.opcode);
    case (dec.opcode)
      instFormatPkg::opAdd, instFormatPkg::opSub,
      instFormatPkg::opAnd, instFormatPkg::opOr:    dec.instClass = instFormatPkg::classAlu;
      instFormatPkg::opLoad, instFormatPkg::opStore: dec.instClass = instFormatPkg::classMem;
      instFormatPkg::opBranch, instFormatPkg::opJump: dec.instClass = instFormatPkg::classCtrl;
      default:                                       dec.instClass = instFormatPkg::classBad;
    endcase
    dec.isBranch = (dec.opcode == instFormatPkg::opBranch) ||
                   (dec.opcode == instFormatPkg::opJump);  // Jumps count as branches too.
    dec.rd  = raw.rd;
    dec.rs  = raw.rs;
    dec.imm = {{(`INST_WIDTH-4){raw.imm4[3]}}, raw.imm4};  // Sign extension.
    dec.pc  = lanePc;
    return dec;
  endfunction

  assign accept = fetchValid_i & ~stallFetch_i;  // Fetch handshake.

  // Every lane is decoded, valid or not. The lane-valid vector travels along
  // and tells the queue which lanes to keep.
  always_comb begin
    decodedNext.laneValid = fetchBundle_i.laneValid;
    for (int lane = 0; lane < `FETCH_WIDTH; lane++) begin
      decodedNext.lane[lane] = decodeLane(fetchBundle_i.lane[lane],
                                          fetchBundle_i.basePc + `INST_WIDTH'(lane));
    end
  end

  // The valid flag is control state and clears on reset and flush.
  always_ff @(posedge clk) begin
    if (!rstN_i || flush_i) begin
      decodedValid_o <= 1'b0;
    end else begin
      decodedValid_o <= accept;  // Drops the cycle after no bundle was taken.
    end
  end

  // The payload only loads on an accepted bundle.
  always_ff @(posedge clk) begin
    if (accept) begin
      decodedBundle_o <= decodedNext;
    end
  end

endmodule

// ==== source/instQueue.sv ====
`include "frontEnd_cfg.svh"

// Circular instruction queue between decode and dispatch.
// Up to FETCH_WIDTH lanes are written per cycle at the tail, compacted so that
// holes in the lane-valid vector leave no gaps. Groups of DISPATCH_WIDTH leave
// from the head.
module instQueue (
  input  logic                      clk,
  input  logic                      rstN_i,
  input  logic                      flush_i,
  input  logic                      decodedValid_i,
  input  bundlePkg::decodedBundleT  decodedBundle_i,
  output logic                      stallFetch_o,
  input  logic                      dispatchStall_i,
  output logic                      dispatchValid_o,
  output bundlePkg::dispatchBundleT dispatchBundle_o,
  output logic [1:0]                branchCount_o
);

  localparam int PtrW   = `IQ_DEPTH_LOG;
  localparam int CountW = `IQ_DEPTH_LOG + 1;  // Must hold the value IQ_DEPTH itself.

  // Stall threshold. Room is kept for the bundle inside the decoder plus the
  // one being accepted on the same edge as the stall is sampled.
  localparam int StallLimit = `IQ_DEPTH - 2 * `FETCH_WIDTH;

  instFormatPkg::decodedInstT iqMem [`IQ_DEPTH];  // Entry storage.

  logic [PtrW-1:0]         headPtr;      // Oldest entry.
  logic [PtrW-1:0]         tailPtr;      // First free entry.
  logic [CountW-1:0]       count;        // Occupied entries.
  logic [CountW-1:0]       countNext;
  logic [CountW-1:0]       writeCount;   // Popcount of the lanes written this cycle.
  logic [`FETCH_WIDTH-1:0] writeEnable;
  logic [PtrW-1:0]         laneOffset [`FETCH_WIDTH];  // Valid lanes below each lane.
  logic                    dispatchFire;  // A group leaves on this edge.

  // Compaction. Each lane is placed after all valid lanes below it, so the
  // offset is a running popcount. A flush cancels the write.
  always_comb begin
    writeCount = '0;
    for (int lane = 0; lane < `FETCH_WIDTH; lane++) begin
      laneOffset[lane]  = writeCount[PtrW-1:0];
      writeEnable[lane] = decodedValid_i & decodedBundle_i.laneValid[lane] & ~flush_i;
      writeCount        = writeCount + CountW'(writeEnable[lane]);
    end
  end

  // Storage has no reset. Only the pointers and the count say what is live.
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < `FETCH_WIDTH; lane++) begin
      if (writeEnable[lane]) begin
        iqMem[tailPtr + laneOffset[lane]] <= decodedBundle_i.lane[lane];  // Wraps at depth.
      end
    end
  end

  // Head read is combinational, so the group stays put while dispatch stalls.
  always_comb begin
    branchCount_o = '0;
    for (int slotIdx = 0; slotIdx < `DISPATCH_WIDTH; slotIdx++) begin
      dispatchBundle_o.slot[slotIdx] = iqMem[headPtr + PtrW'(slotIdx)];
      branchCount_o = branchCount_o + 2'(dispatchBundle_o.slot[slotIdx].isBranch);
    end
  end

  assign dispatchValid_o = (count >= CountW'(`DISPATCH_WIDTH));  // Full groups only.
  assign dispatchFire    = dispatchValid_o & ~dispatchStall_i;
  assign stallFetch_o    = (count > CountW'(StallLimit));

  // Occupancy bookkeeping.
  // Writes always land, and a group only subtracts when it actually leaves.
  always_comb begin
    countNext = count + writeCount;
    if (dispatchFire) begin
      countNext = countNext - CountW'(`DISPATCH_WIDTH);
    end
  end

  // Flush wins over every read and write in the same cycle.
  always_ff @(posedge clk) begin
    if (!rstN_i || flush_i) begin
      headPtr <= '0;
      tailPtr <= '0;
      count   <= '0;
    end else begin
      tailPtr <= tailPtr + writeCount[PtrW-1:0];  // At most FETCH_WIDTH, fits the pointer.
      if (dispatchFire) begin
        headPtr <= headPtr + PtrW'(`DISPATCH_WIDTH);
      end
      count <= countNext;
    end
  end

endmodule

// ==== source/frontEndTop.sv ====
`include "frontEnd_cfg.svh"

// Front-end slice. Decode stage followed by the instruction queue.
module frontEndTop (
  input  logic                      clk,
  input  logic                      rstN_i,
  input  logic                      flush_i,
  input  logic                      fetchValid_i,
  input  bundlePkg::fetchBundleT    fetchBundle_i,
  output logic                      stallFetch_o,
  input  logic                      dispatchStall_i,
  output logic                      dispatchValid_o,
  output bundlePkg::dispatchBundleT dispatchBundle_o,
  output logic [1:0]                branchCount_o
);

  logic                     queueStall;     // One stall serves decoder and fetch.
  logic                     decodedValid;
  bundlePkg::decodedBundleT decodedBundle;

  assign stallFetch_o = queueStall;

  instDecoder instDecoder_i (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .flush_i         (flush_i),
    .fetchValid_i    (fetchValid_i),
    .fetchBundle_i   (fetchBundle_i),
    .stallFetch_i    (queueStall),
    .decodedValid_o  (decodedValid),
    .decodedBundle_o (decodedBundle)
  );

  instQueue instQueue_i (
    .clk              (clk),
    .rstN_i           (rstN_i),
    .flush_i          (flush_i),
    .decodedValid_i   (decodedValid),
    .decodedBundle_i  (decodedBundle),
    .stallFetch_o     (queueStall),
    .dispatchStall_i  (dispatchStall_i),
    .dispatchValid_o  (dispatchValid_o),
    .dispatchBundle_o (dispatchBundle_o),
    .branchCount_o    (branchCount_o)
  );

endmodule

// ==== verification/frontEnd_props.sv ====
`include "frontEnd_cfg.svh"

// Queue invariants. The module is bound into every instQueue instance.
module frontEndProps (
  input logic                     clk,
  input logic                     rstN_i,
  input logic                     flush_i,
  input logic [`IQ_DEPTH_LOG:0]   count_i,          // Occupancy of the queue.
  input logic                     decodedValid_i,
  input logic [`FETCH_WIDTH-1:0]  laneValid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int assertFails = 0;  // Number of assertion failures so far.

  // The count can never pass the number of entries.
  countBound: assert property (@(posedge clk) disable iff (!rstN_i) count_i <= `IQ_DEPTH)
    else begin
      $error("Queue count exceeds the queue depth");
      assertFails++;
    end

  // The early stall must leave room for any write that still arrives.
  writeHasRoom: assert property (@(posedge clk) disable iff (!rstN_i)
      (decodedValid_i && |laneValid_i) |-> count_i <= `IQ_DEPTH - `FETCH_WIDTH)
    else begin
      $error("Write arrived with too little room left in the queue");
      assertFails++;
    end

  // A flush also clears the decoder register. No write reaches the queue on the next edge.
  flushEmpties: assert property (@(posedge clk) disable iff (!rstN_i)
      flush_i |=> !decodedValid_i)
    else begin
      $error("Decoder still held a bundle after a flush");
      assertFails++;
    end

endmodule

bind instQueue frontEndProps frontEndProps_i (
  .clk             (clk),
  .rstN_i          (rstN_i),
  .flush_i         (flush_i),
  .count_i         (count),
  .decodedValid_i  (decodedValid_i),
  .laneValid_i     (decodedBundle_i.laneValid)
);

// ==== verification/frontEndTb.sv ====
`include "frontEnd_cfg.svh"

module frontEndTb;
  timeunit 1ns;
  timeprecision 100ps;

  // Phase lengths in cycles.
  localparam int LenNormal = 300;
  localparam int LenBackPressure = 200;
  localparam int LenFlush = 300;
  localparam int LenDrain = 60;
  localparam int TimeoutCycles = (LenNormal + LenBackPressure + LenFlush + LenDrain) * 2 + 100;

  logic                      clk;
  logic                      rstN_i;
  logic                      flush_i;
  logic                      fetchValid_i;
  bundlePkg::fetchBundleT    fetchBundle_i;
  logic                      stallFetch_o;
  logic                      dispatchStall_i;
  logic                      dispatchValid_o;
  bundlePkg::dispatchBundleT dispatchBundle_o;
  logic [1:0]                branchCount_o;

  instFormatPkg::decodedInstT modelQ [$];  // Accepted but not yet dispatched. Oldest in front.
  logic [31:0] rngState = 32'hd128;
  logic [15:0] pcCounter = 16'h0100;
  int          errorCount = 0;
  int          cycleCount = 0;
  logic        flushLast = 1'b0;   // Flush was seen on the previous edge.
  logic        stallSeen = 1'b0;   // stallFetch_o went high under back-pressure.
  string       phaseName = "reset";

  frontEndTop frontEndTop_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period.
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Returns the upper half of the LCG state. The low bits cycle too fast to be useful.
  function automatic logic [15:0] nextRandom();
    rngState = lcgNext(rngState);
    return rngState[31:16];
  endfunction

  // Reference decode. It follows the opcode table of the instruction format.
  function automatic instFormatPkg::decodedInstT modelDecode(input instFormatPkg::rawInstT raw,
                                                             input logic [15:0] pc);
    instFormatPkg::decodedInstT d;
    d.opcode    = instFormatPkg::opcodeT'(raw.opcode);
    d.isBranch  = 1'b0;
    case (raw.opcode)
      4'd0, 4'd1, 4'd2, 4'd3: d.instClass = instFormatPkg::classAlu;
      4'd4, 4'd5:             d.instClass = instFormatPkg::classMem;
      4'd6, 4'd7: begin
        d.instClass = instFormatPkg::classCtrl;
        d.isBranch  = 1'b1;  // Branch and jump.
      end
      default: begin
        d.opcode    = instFormatPkg::opIllegal;
        d.instClass = instFormatPkg::classBad;
      end
    endcase
    d.rd  = raw.rd;
    d.rs  = raw.rs;
    d.imm = raw.imm4[3] ? {12'hfff, raw.imm4} : {12'h000, raw.imm4};
    d.pc  = pc;
    return d;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s/%s: expected %h, actual %h", phaseName, name, expected, actual);
    end
  endtask

  // Drives one cycle of random stimulus. The percentages are out of 100.
  task automatic driveCycle(input int fetchPct, input int stallPct, input int flushPct);
    bundlePkg::fetchBundleT bundle;
    logic [15:0] r;
    r = nextRandom();
    bundle.laneValid = r[`FETCH_WIDTH-1:0];  // Sparse vectors. All zero is included too.
    bundle.basePc    = pcCounter;
    for (int k = 0; k < `FETCH_WIDTH; k++) begin
      bundle.lane[k] = instFormatPkg::rawInstT'(nextRandom());
    end
    pcCounter += 16'(`FETCH_WIDTH);
    fetchBundle_i   <= bundle;
    fetchValid_i    <= (nextRandom() % 100) < fetchPct;
    dispatchStall_i <= (nextRandom() % 100) < stallPct;
    flush_i         <= (nextRandom() % 100) < flushPct;
  endtask

  task automatic runPhase(input string name, input int cycles, input int fetchPct,
                          input int stallPct, input int flushPct);
    phaseName <= name;  // The model sees the new phase from the next edge on.
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      driveCycle(fetchPct, stallPct, flushPct);
    end
  endtask

  // The model updates on every edge from the values held before the edge.
  always @(posedge clk) begin : modelUpdate
    instFormatPkg::decodedInstT expOld;
    instFormatPkg::decodedInstT expNew;
    if (rstN_i) begin
      if (flushLast) checkValue("flushDispatchValid", 0, dispatchValid_o);
      if (flush_i) begin
        modelQ.delete();  // Decoder stage and queue both empty.
      end else begin
        if (dispatchValid_o && !dispatchStall_i) begin
          if (modelQ.size() < 2) begin
            errorCount++;
            $display("Group dispatched while the model held fewer than two instructions");
          end else begin
            expOld = modelQ.pop_front();
            expNew = modelQ.pop_front();
            checkValue("dispatchSlot0", expOld, dispatchBundle_o.slot[0]);
            checkValue("dispatchSlot1", expNew, dispatchBundle_o.slot[1]);
            checkValue("branchCount", 64'(expOld.isBranch) + 64'(expNew.isBranch),
                       branchCount_o);
          end
        end
        // New lanes go in after the pop. They cannot leave on this edge anyway.
        if (fetchValid_i && !stallFetch_o) begin
          for (int k = 0; k < `FETCH_WIDTH; k++) begin
            if (fetchBundle_i.laneValid[k]) begin
              modelQ.push_back(modelDecode(fetchBundle_i.lane[k],
                                           fetchBundle_i.basePc + 16'(k)));
            end
          end
        end
        // Queue entries plus one bundle in the decoder.
        checkValue("modelOccupancy", 1, modelQ.size() <= `IQ_DEPTH + `FETCH_WIDTH);
      end
      if (stallFetch_o && phaseName == "backPressure") stallSeen = 1'b1;
      flushLast = flush_i;
    end
  end

  initial begin : timeoutWatch
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Run timed out after %0d cycles before the tests ended", cycleCount);
    errorCount++;
    $display("Errors: %0d", errorCount);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    rstN_i          = 1'b0;
    flush_i         = 1'b0;
    fetchValid_i    = 1'b0;
    fetchBundle_i   = '0;
    dispatchStall_i = 1'b0;
    @(posedge clk);  // First edge clears the state.
    repeat (2) begin
      @(posedge clk);
      checkValue("resetDispatchValid", 0, dispatchValid_o);
      checkValue("resetStallFetch", 0, stallFetch_o);
    end
    rstN_i <= 1'b1;  // Released after three reset edges.
    @(posedge clk);
    checkValue("postResetDispatchValid", 0, dispatchValid_o);
    checkValue("postResetStallFetch", 0, stallFetch_o);
    runPhase("normal", LenNormal, 70, 20, 0);
    runPhase("backPressure", LenBackPressure, 90, 90, 0);
    runPhase("flush", LenFlush, 70, 30, 3);
    runPhase("drain", LenDrain, 0, 0, 0);
    @(negedge clk);  // Let the model take the last edge.
    checkValue("drainEmpty", 1, modelQ.size() < 2);
    checkValue("stallSeen", 1, stallSeen);
    checkValue("assertionFailures", 0, frontEndTop_i.instQueue_i.frontEndProps_i.assertFails);
    $display("Errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== frontEnd.f ====
+incdir+source
source/instFormatPkg.sv
source/bundlePkg.sv
source/instDecoder.sv
source/instQueue.sv
source/frontEndTop.sv
verification/frontEnd_props.sv
verification/frontEndTb.sv

// ==== Bender.yml ====
package:
  name: frontEnd

sources:
  - include_dirs:
      - source
    files:
      - source/instFormatPkg.sv
      - source/bundlePkg.sv
      - source/instDecoder.sv
      - source/instQueue.sv
      - source/frontEndTop.sv

  - target: test
    include_dirs:
      - source
    files:
      - verification/frontEnd_props.sv
      - verification/frontEndTb.sv
